// File: src/memStagePkg.sv
// ========================================================================
// Shared types for the memory-access stage: operation kinds, MIPS cause
// codes and the two payloads that travel between the stage blocks.
// ========================================================================

`default_nettype none

package memStagePkg;

    // load and store kinds coming from execute
    typedef enum logic [3:0] {
        LB,
        LBU,
        LH,
        LHU,
        LW,
        SB,
        SH,
        SW
    } memOpE;

    // subset of the CP0 cause ExcCode field
    typedef enum logic [4:0] {
        EXC_NONE = 5'd0,
        EXC_ADEL = 5'd4,
        EXC_ADES = 5'd5
    } excCodeE;

    // execute to memory operation
    typedef struct packed {
        memOpE       op;
        logic [31:0] addr;
        logic [31:0] storeData;
        logic [4:0]  dst;
    } exMemT;

    // checked and translated access into the RAM stage
    typedef struct packed {
        memOpE       op;
        logic [29:0] wordAddr;
        logic [3:0]  byteEn;
        logic [31:0] wdata;
        logic [1:0]  byteOffset;
        logic [4:0]  dst;
        excCodeE     excCode;
        logic [31:0] badVAddr;
    } accessT;

endpackage

`default_nettype wire

// File: src/memChanIf.sv
// ========================================================================
// Valid/ready channel between the stage blocks. The payload type is set
// per instance; a beat moves on a clock edge with valid and ready high.
// ========================================================================

`default_nettype none

interface memChanIf #(
    parameter type payloadT = logic
);

    logic    valid;
    logic    ready;
    payloadT payload;

    // sender holds valid and payload until the beat is taken
    modport sender (
        output valid,
        output payload,
        input  ready
    );

    // ready is allowed to look at valid
    modport receiver (
        input  valid,
        input  payload,
        output ready
    );

endinterface

`default_nettype wire

// File: src/memStageReg.sv
// ========================================================================
// Execute-to-memory pipeline register. Holds one operation and refills
// in the same cycle its output beat is taken, so the stream runs at one
// operation per clock.
// ========================================================================

`default_nettype none

module memStageReg (
    input  logic               clk,
    input  logic               rstN,
    input  logic               inValid,
    output logic               inReady,
    input  memStagePkg::memOpE inOp,
    input  logic [31:0]        inAddr,
    input  logic [31:0]        inStoreData,
    input  logic [4:0]         inDst,
    memChanIf.sender           outChan
);

    import memStagePkg::*;

    logic  full;
    exMemT holdQ;

    // free slot, or the held op leaves this cycle
    assign inReady = !full || outChan.ready;

    assign outChan.valid   = full;
    assign outChan.payload = holdQ;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            full <= 1'b0;
        end else if (inReady) begin
            full <= inValid;
        end
    end

    always_ff @(posedge clk) begin
        if (inValid && inReady) begin
            holdQ <= '{
                op:        inOp,
                addr:      inAddr,
                storeData: inStoreData,
                dst:       inDst
            };
        end
    end

endmodule

`default_nettype wire

// File: src/memAddrCheck.sv
// ========================================================================
// Address check between the stage register and the RAM. Maps kseg0 and
// kseg1 to physical addresses, raises AdEL or AdES, and lines store data
// up with its byte lanes. Purely combinational on the handshake.
// ========================================================================

`default_nettype none

module memAddrCheck (
    memChanIf.receiver inChan,
    memChanIf.sender   outChan
);

    import memStagePkg::*;

    exMemT       req;
    accessT      acc;
    logic        isStore;
    logic        segOk;
    logic        alignOk;
    logic [1:0]  offset;
    logic [31:0] physAddr;

    assign req = inChan.payload;

    // no buffering here, handshake passes straight through
    assign outChan.valid   = inChan.valid;
    assign inChan.ready    = outChan.ready;
    assign outChan.payload = acc;

    always_comb begin
        isStore = req.op inside {SB, SH, SW};
        offset  = req.addr[1:0];

        // kseg0 is 3'b100 and kseg1 is 3'b101
        segOk    = req.addr[31:30] == 2'b10;
        physAddr = {3'b000, req.addr[28:0]};

        case (req.op)
            LH, LHU, SH: alignOk = !offset[0];
            LW, SW:      alignOk = offset == 2'b00;
            default:     alignOk = 1'b1;
        endcase

        acc.op         = req.op;
        acc.wordAddr   = physAddr[31:2];
        acc.byteOffset = offset;
        acc.dst        = req.dst;
        acc.excCode    = EXC_NONE;
        acc.badVAddr   = '0;
        acc.byteEn     = '0;
        acc.wdata      = '0;

        if (!segOk || !alignOk) begin
            acc.excCode  = isStore ? EXC_ADES : EXC_ADEL;
            acc.badVAddr = req.addr;
        end else if (isStore) begin
            // shift into the addressed lane
            case (req.op)
                SB: begin
                    acc.wdata  = {24'b0, req.storeData[7:0]} << {offset, 3'b000};
                    acc.byteEn = 4'b0001 << offset;
                end
                SH: begin
                    acc.wdata  = {16'b0, req.storeData[15:0]} << {offset, 3'b000};
                    acc.byteEn = offset[1] ? 4'b1100 : 4'b0011;
                end
                default: begin
                    acc.wdata  = req.storeData;
                    acc.byteEn = 4'b1111;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: src/memDataRam.sv
// ========================================================================
// Data RAM and result register. Writes by byte enable and reads the old
// word on the same edge, then extends the byte or halfword of a load.
// Holds its result while the consumer stalls.
// ========================================================================

`default_nettype none

module memDataRam #(
    parameter int RAM_ADDR_BITS = 6
) (
    input  logic                 clk,
    input  logic                 rstN,
    memChanIf.receiver           inChan,
    output logic                 resValid,
    input  logic                 resReady,
    output logic [31:0]          resData,
    output logic [4:0]           resDst,
    output logic                 resWrite,
    output memStagePkg::excCodeE resExcCode,
    output logic [31:0]          resBadVAddr
);

    import memStagePkg::*;

    logic [31:0]              ramWords [2**RAM_ADDR_BITS];
    accessT                   req;
    accessT                   held;
    logic [RAM_ADDR_BITS-1:0] idx;
    logic                     take;
    logic [31:0]              rdWord;
    logic [7:0]               rdByte;
    logic [15:0]              rdHalf;
    logic                     fault;

    assign req  = inChan.payload;
    assign idx  = req.wordAddr[RAM_ADDR_BITS-1:0];
    assign take = inChan.valid && inChan.ready;

    // accept only when the result slot frees up
    assign inChan.ready = !resValid || resReady;

    // read-first; byteEn is zero for loads and faults
    always_ff @(posedge clk) begin
        if (take) begin
            rdWord <= ramWords[idx];
            for (int b = 0; b < 4; b++) begin
                if (req.byteEn[b]) begin
                    ramWords[idx][8*b +: 8] <= req.wdata[8*b +: 8];
                end
            end
            held <= req;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            resValid <= 1'b0;
        end else if (inChan.ready) begin
            resValid <= inChan.valid;
        end
    end

    assign rdByte = rdWord[{held.byteOffset, 3'b000} +: 8];
    assign rdHalf = rdWord[{held.byteOffset[1], 4'b0000} +: 16];
    assign fault  = held.excCode != EXC_NONE;

    always_comb begin
        case (held.op)
            LB:      resData = {{24{rdByte[7]}}, rdByte};
            LBU:     resData = {24'b0, rdByte};
            LH:      resData = {{16{rdHalf[15]}}, rdHalf};
            LHU:     resData = {16'b0, rdHalf};
            LW:      resData = rdWord;
            default: resData = '0;
        endcase
        if (fault) begin
            resData = '0;
        end
    end

    // only a clean load writes the register file
    assign resWrite    = !fault && !(held.op inside {SB, SH, SW});
    assign resDst      = held.dst;
    assign resExcCode  = held.excCode;
    assign resBadVAddr = held.badVAddr;

endmodule

`default_nettype wire

// File: src/memStageTop.sv
// ========================================================================
// Memory-access stage top level. Plain valid/ready ports in from execute
// and out to writeback; two operations can be in flight inside.
// ========================================================================

`default_nettype none

module memStageTop #(
    parameter int RAM_ADDR_BITS = 6
) (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 inValid,
    output logic                 inReady,
    input  memStagePkg::memOpE   inOp,
    input  logic [31:0]          inAddr,
    input  logic [31:0]          inStoreData,
    input  logic [4:0]           inDst,
    output logic                 resValid,
    input  logic                 resReady,
    output logic [31:0]          resData,
    output logic [4:0]           resDst,
    output logic                 resWrite,
    output memStagePkg::excCodeE resExcCode,
    output logic [31:0]          resBadVAddr
);

    import memStagePkg::*;

    memChanIf #(.payloadT(exMemT))  regToCheck ();
    memChanIf #(.payloadT(accessT)) checkToRam ();

    memStageReg i_memStageReg (
        .clk         (clk),
        .rstN        (rstN),
        .inValid     (inValid),
        .inReady     (inReady),
        .inOp        (inOp),
        .inAddr      (inAddr),
        .inStoreData (inStoreData),
        .inDst       (inDst),
        .outChan     (regToCheck.sender)
    );

    memAddrCheck i_memAddrCheck (
        .inChan  (regToCheck.receiver),
        .outChan (checkToRam.sender)
    );

    memDataRam #(
        .RAM_ADDR_BITS (RAM_ADDR_BITS)
    ) i_memDataRam (
        .clk         (clk),
        .rstN        (rstN),
        .inChan      (checkToRam.receiver),
        .resValid    (resValid),
        .resReady    (resReady),
        .resData     (resData),
        .resDst      (resDst),
        .resWrite    (resWrite),
        .resExcCode  (resExcCode),
        .resBadVAddr (resBadVAddr)
    );

endmodule

`default_nettype wire

// File: tests/memStage_sva.sv
// ========================================================================
// Handshake and reset assertions for the memory stage, attached to the
// top level by the bind at the end of this file.
// ========================================================================

`default_nettype none

module memStageSva (
    input logic                 clk,
    input logic                 rstN,
    input logic                 inReady,
    input logic                 resValid,
    input logic                 resReady,
    input logic [31:0]          resData,
    input logic [4:0]           resDst,
    input logic                 resWrite,
    input memStagePkg::excCodeE resExcCode,
    input logic [31:0]          resBadVAddr
);

    int assertFails = 0;

    resetEmpty: assert property (@(posedge clk) !rstN |=> !resValid && inReady)
        else begin
            assertFails++;
            $error("result still valid or input blocked right after reset");
        end

    // a stalled result must not move
    holdWhileStalled: assert property (@(posedge clk) disable iff (!rstN)
        resValid && !resReady |=> resValid
            && $stable({resData, resDst, resWrite, resExcCode, resBadVAddr}))
        else begin
            assertFails++;
            $error("result changed or dropped while the consumer stalled");
        end

    emptyAccepts: assert property (@(posedge clk) disable iff (!rstN)
        !resValid |-> inReady)
        else begin
            assertFails++;
            $error("input blocked although no result is held");
        end

endmodule

bind memStageTop memStageSva i_memStageSva (
    .clk         (clk),
    .rstN        (rstN),
    .inReady     (inReady),
    .resValid    (resValid),
    .resReady    (resReady),
    .resData     (resData),
    .resDst      (resDst),
    .resWrite    (resWrite),
    .resExcCode  (resExcCode),
    .resBadVAddr (resBadVAddr)
);

`default_nettype wire

// File: tests/memStageChecker.sv
// ========================================================================
// Checker for the memory stage testbench. Predicts each result from a
// reference word array when an operation enters, then compares the beats
// that leave the DUT in order.
// ========================================================================

`default_nettype none

module memStageChecker (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 inValid,
    input  logic                 inReady,
    input  memStagePkg::memOpE   inOp,
    input  logic [31:0]          inAddr,
    input  logic [31:0]          inStoreData,
    input  logic [4:0]           inDst,
    input  logic                 resValid,
    input  logic                 resReady,
    input  logic [31:0]          resData,
    input  logic [4:0]           resDst,
    input  logic                 resWrite,
    input  memStagePkg::excCodeE resExcCode,
    input  logic [31:0]          resBadVAddr,
    input  int                   ramDepth,
    input  string                testName,
    output int                   errorCount,
    output int                   resultCount
);

    import memStagePkg::*;

    typedef struct packed {
        logic [31:0] data;
        logic [4:0]  dst;
        logic        write;
        excCodeE     exc;
        logic [31:0] badVAddr;
    } resultT;

    logic [31:0] refMem [int];
    resultT      expQ [$];
    string       nameQ [$];

    initial begin
        errorCount  = 0;
        resultCount = 0;
    end

    task automatic compareField(input string name, input string field,
                                input logic [31:0] expV, input logic [31:0] actV);
        if (expV !== actV) begin
            errorCount++;
            $display("mismatch %s %s expected %h actual %h", name, field, expV, actV);
        end
    endtask

    // expected beat from the segment, alignment and lane rules
    task automatic predictOp(input memOpE op, input logic [31:0] addr,
                             input logic [31:0] sdata, input logic [4:0] dst);
        resultT      want;
        int          size;
        int          off;
        int          idx;
        logic [31:0] lane;
        size = (op inside {LB, LBU, SB}) ? 1 : (op inside {LH, LHU, SH}) ? 2 : 4;
        off  = int'(addr[1:0]);
        idx  = int'(addr[28:2]) % ramDepth;
        want = '{data: '0, dst: dst, write: 1'b0, exc: EXC_NONE, badVAddr: '0};
        if (!(addr[31:29] inside {3'b100, 3'b101}) || off % size != 0) begin
            want.exc      = (op inside {SB, SH, SW}) ? EXC_ADES : EXC_ADEL;
            want.badVAddr = addr;
        end else if (op inside {SB, SH, SW}) begin
            lane = refMem.exists(idx) ? refMem[idx] : '0;
            for (int k = 0; k < size; k++) begin
                lane[8*(off+k) +: 8] = sdata[8*k +: 8];
            end
            refMem[idx] = lane;
        end else if (!refMem.exists(idx)) begin
            errorCount++;
            $display("%s load reads a word that no store has written", testName);
        end else begin
            lane      = refMem[idx] >> (8 * off);
            want.write = 1'b1;
            case (op)
                LB:      want.data = {{24{lane[7]}}, lane[7:0]};
                LBU:     want.data = {24'b0, lane[7:0]};
                LH:      want.data = {{16{lane[15]}}, lane[15:0]};
                LHU:     want.data = {16'b0, lane[15:0]};
                default: want.data = lane;
            endcase
        end
        expQ.push_back(want);
        nameQ.push_back(testName);
    endtask

    always @(posedge clk) begin : watchBeats
        resultT want;
        string  name;
        if (rstN && resValid && resReady) begin
            if (expQ.size() == 0) begin
                errorCount++;
                $display("a result beat left the DUT with no operation outstanding");
            end else begin
                want = expQ.pop_front();
                name = nameQ.pop_front();
                resultCount++;
                compareField(name, "data", want.data, resData);
                compareField(name, "dst", want.dst, resDst);
                compareField(name, "write", want.write, resWrite);
                compareField(name, "excCode", want.exc, resExcCode);
                if (want.exc != EXC_NONE) begin
                    compareField(name, "badVAddr", want.badVAddr, resBadVAddr);
                end
            end
        end
        // operations enter the model in acceptance order
        if (rstN && inValid && inReady) begin
            predictOp(inOp, inAddr, inStoreData, inDst);
        end
    end

endmodule

`default_nettype wire

// File: tests/memStageTb.sv
// ========================================================================
// Testbench for the memory stage. Fills the RAM, runs random loads and
// stores with random result stalls, checks segment aliasing, then reads
// every word back. The checker compares and counts errors.
// ========================================================================

`default_nettype none

module memStageTb;

    import memStagePkg::*;

    localparam int RandomOps  = 300;
    localparam int AliasPairs = 16;

    logic        clk;
    logic        rstN;
    logic        inValid;
    logic        inReady;
    memOpE       inOp;
    logic [31:0] inAddr;
    logic [31:0] inStoreData;
    logic [4:0]  inDst;
    logic        resValid;
    logic        resReady;
    logic [31:0] resData;
    logic [4:0]  resDst;
    logic        resWrite;
    excCodeE     resExcCode;
    logic [31:0] resBadVAddr;

    logic [31:0] rngState;
    logic [31:0] readyState = 32'hf8f3;
    int          ramDepth;
    int          opsSent;
    int          cycleLimit;
    int          cycleCount;
    int          errorCount;
    int          resultCount;
    string       testName;

    memStageTop #(
        .RAM_ADDR_BITS (6)
    ) i_memStageTop (.*);

    memStageChecker i_checker (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] nextRand();
        rngState = xorshift(rngState);
        return rngState;
    endfunction

    // result side accepts about three cycles in four
    always @(negedge clk) begin
        if (rstN) begin
            readyState = xorshift(readyState);
            resReady   = readyState[1:0] != 2'b00;
        end
    end

    task automatic sendOp(input memOpE op, input logic [31:0] addr,
                          input logic [31:0] data, input logic [4:0] dst);
        inValid     = 1'b1;
        inOp        = op;
        inAddr      = addr;
        inStoreData = data;
        inDst       = dst;
        do begin
            @(posedge clk);
        end while (!inReady);
        @(negedge clk);
        inValid = 1'b0;
        opsSent++;
    endtask

    task automatic sendRandomOp();
        logic [31:0] r;
        logic [31:0] data;
        logic [26:0] word;
        logic [2:0]  seg;
        logic [1:0]  off;
        memOpE       op;
        r    = nextRand();
        data = nextRand();
        word = 27'(nextRand() % ramDepth);
        op   = memOpE'(r[2:0]);
        seg  = r[3] ? 3'b101 : 3'b100;
        // now and then an address outside kseg0 and kseg1
        if (r[7:4] == 4'd0) begin
            seg = r[10:8] ^ ((r[10:9] == 2'b10) ? 3'b010 : 3'b000);
        end
        case (op)
            LB, LBU, SB: off = r[12:11];
            LH, LHU, SH: off = {r[12], 1'b0};
            default:     off = 2'b00;
        endcase
        if (r[16:13] == 4'd0) begin
            off = r[12:11];
        end
        if (r[31:30] == 2'b00) begin
            @(negedge clk);
        end
        sendOp(op, {seg, word, off}, data, r[21:17]);
    endtask

    initial begin : runTests
        logic [31:0] r;
        logic [26:0] word;
        rngState    = 32'hf8f3;
        rstN        = 1'b0;
        inValid     = 1'b0;
        inOp        = LB;
        inAddr      = '0;
        inStoreData = '0;
        inDst       = '0;
        resReady    = 1'b0;
        opsSent     = 0;
        testName    = "reset";
        ramDepth    = 2 ** i_memStageTop.RAM_ADDR_BITS;
        cycleLimit  = (3 * ramDepth + RandomOps + 2 * AliasPairs) * 8 + 100;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;

        testName = "fillWords";
        for (int i = 0; i < ramDepth; i++) begin
            sendOp(SW, 32'h8000_0000 + 4 * i, nextRand(), 5'(i));
        end
        testName = "readBack";
        for (int i = 0; i < ramDepth; i++) begin
            sendOp(LW, 32'h8000_0000 + 4 * i, '0, 5'(i));
        end
        testName = "randomOps";
        for (int i = 0; i < RandomOps; i++) begin
            sendRandomOp();
        end
        // store through one segment, load through the other
        testName = "segmentAlias";
        for (int i = 0; i < AliasPairs; i++) begin
            r    = nextRand();
            word = 27'(r % ramDepth);
            sendOp(SW, {r[0] ? 3'b101 : 3'b100, word, 2'b00}, nextRand(), 5'd1);
            sendOp(LW, {r[0] ? 3'b100 : 3'b101, word, 2'b00}, '0, 5'd2);
        end
        testName = "mergedWords";
        for (int i = 0; i < ramDepth; i++) begin
            sendOp(LW, 32'hA000_0000 + 4 * i, '0, 5'(i));
        end

        wait (resultCount == opsSent);
        repeat (10) @(posedge clk);
        $display("%0d of %0d results checked, %0d checker errors, %0d assertion failures",
                 resultCount, opsSent, errorCount, i_memStageTop.i_memStageSva.assertFails);
        if (errorCount == 0 && i_memStageTop.i_memStageSva.assertFails == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    initial begin : watchdog
        cycleCount = 0;
        wait (cycleLimit > 0);
        while (cycleCount < cycleLimit) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("timeout after %0d cycles with %0d of %0d results received",
                 cycleCount, resultCount, opsSent);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: memStageTop.f
src/memStagePkg.sv
src/memChanIf.sv
src/memStageReg.sv
src/memAddrCheck.sv
src/memDataRam.sv
src/memStageTop.sv
tests/memStage_sva.sv
tests/memStageChecker.sv
tests/memStageTb.sv

// File: Bender.yml
package:
  name: memStage

sources:
  - src/memStagePkg.sv
  - src/memChanIf.sv
  - src/memStageReg.sv
  - src/memAddrCheck.sv
  - src/memDataRam.sv
  - src/memStageTop.sv
  - target: test
    files:
      - tests/memStage_sva.sv
      - tests/memStageChecker.sv
      - tests/memStageTb.sv
